// ==== uart_bridge_cfg.svh ====
`ifndef UART_BRIDGE_CFG_SVH
`define UART_BRIDGE_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reset values of the configuration registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Clocks per bit minus one
`define UART_BIT_DIV_DEFAULT 16'd7

// Idle bit-times between the high and the low command frame
`define UART_GAP_BITS_DEFAULT 4'd2

// Bit-times a read waits for the response start edge
`define UART_TIMEOUT_BITS_DEFAULT 8'd40

`define UART_PARITY_DEFAULT uart_frame_pkg::PARITY_EVEN

`endif

// ==== uart_frame_pkg.sv ====
package uart_frame_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Serial frame format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    PARITY_NONE = 2'd0,
    PARITY_EVEN = 2'd1,   // Parity bit makes the count of ones even
    PARITY_ODD  = 2'd2
  } parity_mode_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Receive check result
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    FRAME_OK         = 2'd0,
    FRAME_PARITY_ERR = 2'd1,
    FRAME_STOP_ERR   = 2'd2   // Stop bit sampled low or start bit did not hold
  } frame_err_t;

endpackage

// ==== uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  localparam logic CMD_WRITE = 1'b1;   // Bit 15 set selects a register write

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Host command word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef union packed {
    struct packed {
      logic       rw;
      logic [6:0] addr;
      logic [7:0] data;
    } fields;
    logic [1:0][7:0] bytes;   // The serial link sends bytes[1] first
  } cmd_word_t;

  typedef enum logic [1:0] {
    RSP_OK         = 2'd0,
    RSP_PARITY_ERR = 2'd1,
    RSP_STOP_ERR   = 2'd2,
    RSP_TIMEOUT    = 2'd3
  } rsp_status_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Configuration register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    CFG_BIT_DIV = 2'd0,
    CFG_CTRL    = 2'd1,   // Gap bits in 7:4 and parity mode in 1:0
    CFG_TIMEOUT = 2'd2
  } cfg_addr_t;

endpackage

// ==== uart_tx_frame.sv ====
`timescale 1ns/100ps

module uart_tx_frame (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [15:0]                  bit_div,
  input  uart_frame_pkg::parity_mode_t parity,
  input  logic                         tx_start,
  input  logic [7:0]                   tx_byte,
  output logic                         tx,
  output logic                         tx_done
);

  logic        active;
  logic [15:0] bit_cnt;
  logic [3:0]  bit_idx;   // 0 start, 1 to 8 data, then parity and stop
  logic [7:0]  shift_q;
  logic        par_q;
  logic        par_en;
  logic [3:0]  last_idx;
  logic        bit_end;

  assign par_en   = (parity != uart_frame_pkg::PARITY_NONE);
  assign last_idx = par_en ? 4'd10 : 4'd9;   // Position of the stop bit
  assign bit_end  = (bit_cnt == bit_div);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active  <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
      tx_done <= 1'b0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (!active)
      begin
        if (tx_start)
        begin
          active  <= 1'b1;
          bit_cnt <= '0;
          bit_idx <= '0;
          tx      <= 1'b0;
        end
      end
      else if (!bit_end)
        bit_cnt <= bit_cnt + 16'd1;
      else
      begin
        bit_cnt <= '0;
        if (bit_idx == last_idx)
        begin
          active  <= 1'b0;
          tx_done <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 4'd1;
          if (bit_idx < 4'd8)
            tx <= shift_q[0];
          else if (bit_idx == 4'd8 && par_en)
            tx <= par_q;
          else
            tx <= 1'b1;
        end
      end
    end
  end

  // Parity is fixed when the byte is taken, the shift register then feeds tx LSB first
  always_ff @(posedge clk)
  begin
    if (!active && tx_start)
    begin
      shift_q <= tx_byte;
      par_q   <= ^tx_byte ^ (parity == uart_frame_pkg::PARITY_ODD);
    end
    else if (active && bit_end && bit_idx < 4'd8)
      shift_q <= shift_q >> 1;
  end

endmodule

// ==== uart_rx_frame.sv ====
`timescale 1ns/100ps

module uart_rx_frame (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [15:0]                  bit_div,
  input  uart_frame_pkg::parity_mode_t parity,
  input  logic                         rx_arm,
  input  logic                         rx,
  output logic                         rx_start_seen,
  output logic                         rx_done,
  output logic [7:0]                   rx_byte,
  output uart_frame_pkg::frame_err_t   rx_err
);

  localparam logic [1:0] RX_HUNT  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_BITS  = 2'd2;

  logic [1:0]  state;
  logic        rx_meta;
  logic        rx_sync;
  logic        rx_prev;
  logic [15:0] bit_cnt;
  logic [3:0]  bit_idx;
  logic [7:0]  shift_q;
  logic        par_en;
  logic        par_exp;
  logic        par_bad;
  logic [3:0]  stop_idx;
  logic        bit_end;

  assign par_en   = (parity != uart_frame_pkg::PARITY_NONE);
  assign stop_idx = par_en ? 4'd10 : 4'd9;
  assign par_exp  = ^shift_q ^ (parity == uart_frame_pkg::PARITY_ODD);
  assign rx_byte  = shift_q;

  // Half a bit from the edge to mid start bit, then whole bits
  assign bit_end = (state == RX_START) ? (bit_cnt == {1'b0, bit_div[15:1]})
                                       : (bit_cnt == bit_div);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame sampling
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= RX_HUNT;
      bit_cnt       <= '0;
      bit_idx       <= '0;
      par_bad       <= 1'b0;
      rx_start_seen <= 1'b0;
      rx_done       <= 1'b0;
      rx_err        <= uart_frame_pkg::FRAME_OK;
    end
    else
    begin
      rx_start_seen <= 1'b0;
      rx_done       <= 1'b0;
      if (!rx_arm)
        state <= RX_HUNT;
      else
        case (state)
          RX_HUNT:
            if (rx_prev && !rx_sync)
            begin
              state         <= RX_START;
              bit_cnt       <= '0;
              rx_start_seen <= 1'b1;
            end
          RX_START:
            if (!bit_end)
              bit_cnt <= bit_cnt + 16'd1;
            else if (rx_sync)
            begin
              // A start glitch still ends the frame, as a framing error
              state   <= RX_HUNT;
              rx_done <= 1'b1;
              rx_err  <= uart_frame_pkg::FRAME_STOP_ERR;
            end
            else
            begin
              state   <= RX_BITS;
              bit_cnt <= '0;
              bit_idx <= 4'd1;
              par_bad <= 1'b0;
            end
          RX_BITS:
            if (!bit_end)
              bit_cnt <= bit_cnt + 16'd1;
            else
            begin
              bit_cnt <= '0;
              bit_idx <= bit_idx + 4'd1;
              if (bit_idx == stop_idx)
              begin
                state   <= RX_HUNT;
                rx_done <= 1'b1;
                if (!rx_sync)
                  rx_err <= uart_frame_pkg::FRAME_STOP_ERR;
                else if (par_bad)
                  rx_err <= uart_frame_pkg::FRAME_PARITY_ERR;
                else
                  rx_err <= uart_frame_pkg::FRAME_OK;
              end
              else if (bit_idx == 4'd9)
                par_bad <= (rx_sync != par_exp);   // Parity bit slot
            end
          default:
            state <= RX_HUNT;
        endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_arm && state == RX_BITS && bit_end && bit_idx <= 4'd8)
      shift_q <= {rx_sync, shift_q[7:1]};   // Data arrives LSB first
  end

endmodule

// ==== uart_cmd_ctrl.sv ====
`timescale 1ns/100ps

module uart_cmd_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  uart_cmd_pkg::cmd_word_t     cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  output logic                        busy,
  input  logic [15:0]                 bit_div,
  input  logic [3:0]                  gap_bits,
  input  logic [7:0]                  timeout_bits,
  output logic                        tx_start,
  output logic [7:0]                  tx_byte,
  input  logic                        tx_done,
  output logic                        rx_arm,
  input  logic                        rx_start_seen,
  input  logic                        rx_done,
  input  logic [7:0]                  rx_byte,
  input  uart_frame_pkg::frame_err_t  rx_err,
  output logic [7:0]                  read_data,
  output logic                        read_rdy,
  output uart_cmd_pkg::rsp_status_t   read_status
);

  localparam logic [2:0] ST_IDLE     = 3'd0;
  localparam logic [2:0] ST_FRAME_HI = 3'd1;
  localparam logic [2:0] ST_GAP      = 3'd2;
  localparam logic [2:0] ST_FRAME_LO = 3'd3;
  localparam logic [2:0] ST_RSP_WAIT = 3'd4;
  localparam logic [2:0] ST_REPORT   = 3'd5;

  logic [2:0]              state;
  uart_cmd_pkg::cmd_word_t cmd_q;
  logic [15:0]             bit_cnt;
  logic [7:0]              bt_cnt;   // Bit-times spent in the gap or the response wait
  logic                    bit_tick;
  logic                    started;

  assign cmd_rdy  = (state == ST_IDLE);
  assign busy     = ~cmd_rdy;
  assign bit_tick = (bit_cnt == bit_div);

  function automatic uart_cmd_pkg::rsp_status_t map_err(
    input uart_frame_pkg::frame_err_t err
  );
    case (err)
      uart_frame_pkg::FRAME_PARITY_ERR: map_err = uart_cmd_pkg::RSP_PARITY_ERR;
      uart_frame_pkg::FRAME_STOP_ERR:   map_err = uart_cmd_pkg::RSP_STOP_ERR;
      default:                          map_err = uart_cmd_pkg::RSP_OK;
    endcase
  endfunction

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      cmd_q <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= ST_IDLE;
      bit_cnt     <= '0;
      bt_cnt      <= '0;
      started     <= 1'b0;
      tx_start    <= 1'b0;
      tx_byte     <= '0;
      rx_arm      <= 1'b0;
      read_rdy    <= 1'b0;
      read_data   <= '0;
      read_status <= uart_cmd_pkg::RSP_OK;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        ST_IDLE:
          if (cmd_vld)
          begin
            state    <= ST_FRAME_HI;
            tx_start <= 1'b1;
            tx_byte  <= cmd_in.bytes[1];
          end
        ST_FRAME_HI:
          if (tx_done)
          begin
            state   <= ST_GAP;
            bit_cnt <= '0;
            bt_cnt  <= '0;
          end
        ST_GAP:
          if (bt_cnt == {4'd0, gap_bits})
          begin
            state    <= ST_FRAME_LO;
            tx_start <= 1'b1;
            tx_byte  <= cmd_q.bytes[0];
          end
          else if (bit_tick)
          begin
            bit_cnt <= '0;
            bt_cnt  <= bt_cnt + 8'd1;
          end
          else
            bit_cnt <= bit_cnt + 16'd1;
        ST_FRAME_LO:
          if (tx_done)
          begin
            if (cmd_q.fields.rw == uart_cmd_pkg::CMD_WRITE)
              state <= ST_IDLE;
            else
            begin
              state   <= ST_RSP_WAIT;
              rx_arm  <= 1'b1;
              started <= 1'b0;
              bit_cnt <= '0;
              bt_cnt  <= '0;
            end
          end
        ST_RSP_WAIT:
          if (rx_done)
          begin
            state       <= ST_REPORT;
            rx_arm      <= 1'b0;
            read_rdy    <= 1'b1;
            read_data   <= rx_byte;
            read_status <= map_err(rx_err);
          end
          else if (!started && !rx_start_seen && bt_cnt == timeout_bits)
          begin
            state       <= ST_REPORT;
            rx_arm      <= 1'b0;
            read_rdy    <= 1'b1;
            read_data   <= 8'h00;
            read_status <= uart_cmd_pkg::RSP_TIMEOUT;
          end
          else if (rx_start_seen)
            started <= 1'b1;   // Timeout count freezes once a frame is under way
          else if (!started)
          begin
            if (bit_tick)
            begin
              bit_cnt <= '0;
              bt_cnt  <= bt_cnt + 8'd1;
            end
            else
              bit_cnt <= bit_cnt + 16'd1;
          end
        ST_REPORT:
          state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== uart_cfg_regs.sv ====
`timescale 1ns/100ps
`include "uart_bridge_cfg.svh"

module uart_cfg_regs (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cfg_wr,
  input  uart_cmd_pkg::cfg_addr_t      cfg_addr,
  input  logic [15:0]                  cfg_wdata,
  input  logic                         busy,
  output logic [15:0]                  cfg_rdata,
  output logic [15:0]                  bit_div,
  output uart_frame_pkg::parity_mode_t parity,
  output logic [3:0]                   gap_bits,
  output logic [7:0]                   timeout_bits
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_div      <= `UART_BIT_DIV_DEFAULT;
      parity       <= `UART_PARITY_DEFAULT;
      gap_bits     <= `UART_GAP_BITS_DEFAULT;
      timeout_bits <= `UART_TIMEOUT_BITS_DEFAULT;
    end
    else if (cfg_wr && !busy)   // Settings hold still while a command is in flight
    begin
      case (cfg_addr)
        uart_cmd_pkg::CFG_BIT_DIV:
          bit_div <= cfg_wdata;
        uart_cmd_pkg::CFG_CTRL:
        begin
          // Code 3 is reserved and taken as no parity
          parity   <= (cfg_wdata[1:0] == 2'b11) ? uart_frame_pkg::PARITY_NONE
                                                : uart_frame_pkg::parity_mode_t'(cfg_wdata[1:0]);
          gap_bits <= cfg_wdata[7:4];
        end
        uart_cmd_pkg::CFG_TIMEOUT:
          timeout_bits <= cfg_wdata[7:0];
        default:
          ;
      endcase
    end
  end

  always_comb
  begin
    case (cfg_addr)
      uart_cmd_pkg::CFG_BIT_DIV: cfg_rdata = bit_div;
      uart_cmd_pkg::CFG_CTRL:    cfg_rdata = {8'h00, gap_bits, 2'b00, parity};
      uart_cmd_pkg::CFG_TIMEOUT: cfg_rdata = {8'h00, timeout_bits};
      default:                   cfg_rdata = 16'h0000;
    endcase
  end

endmodule

// ==== uart_bridge.sv ====
`timescale 1ns/100ps

module uart_bridge (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [15:0]               cmd_in,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,
  output logic [7:0]                read_data,
  output logic                      read_rdy,
  output uart_cmd_pkg::rsp_status_t read_status,
  output logic                      tx,
  input  logic                      rx,
  input  logic                      cfg_wr,
  input  uart_cmd_pkg::cfg_addr_t   cfg_addr,
  input  logic [15:0]               cfg_wdata,
  output logic [15:0]               cfg_rdata,
  output logic                      busy
);

  logic [15:0]                  bit_div;
  uart_frame_pkg::parity_mode_t parity;
  logic [3:0]                   gap_bits;
  logic [7:0]                   timeout_bits;
  logic                         tx_start;
  logic [7:0]                   tx_byte;
  logic                         tx_done;
  logic                         rx_arm;
  logic                         rx_start_seen;
  logic                         rx_done;
  logic [7:0]                   rx_byte;
  uart_frame_pkg::frame_err_t   rx_err;

  uart_cfg_regs uart_cfg_regs_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .busy         (busy),
    .cfg_rdata    (cfg_rdata),
    .bit_div      (bit_div),
    .parity       (parity),
    .gap_bits     (gap_bits),
    .timeout_bits (timeout_bits)
  );

  uart_cmd_ctrl uart_cmd_ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .busy          (busy),
    .bit_div       (bit_div),
    .gap_bits      (gap_bits),
    .timeout_bits  (timeout_bits),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_done       (tx_done),
    .rx_arm        (rx_arm),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte),
    .rx_err        (rx_err),
    .read_data     (read_data),
    .read_rdy      (read_rdy),
    .read_status   (read_status)
  );

  uart_tx_frame uart_tx_frame_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .bit_div  (bit_div),
    .parity   (parity),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_frame uart_rx_frame_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .bit_div       (bit_div),
    .parity        (parity),
    .rx_arm        (rx_arm),
    .rx            (rx),
    .rx_start_seen (rx_start_seen),
    .rx_done       (rx_done),
    .rx_byte       (rx_byte),
    .rx_err        (rx_err)
  );

endmodule

// ==== uart_bridge_tb.sv ====
`timescale 1ns/100ps
`include "uart_bridge_cfg.svh"

module uart_bridge_tb;

  logic                         clk;
  logic                         rst_n;
  logic [15:0]                  cmd_in;
  logic                         cmd_vld;
  logic                         cmd_rdy;
  logic [7:0]                   read_data;
  logic                         read_rdy;
  uart_cmd_pkg::rsp_status_t    read_status;
  logic                         tx;
  logic                         rx;
  logic                         cfg_wr;
  uart_cmd_pkg::cfg_addr_t      cfg_addr;
  logic [15:0]                  cfg_wdata;
  logic [15:0]                  cfg_rdata;
  logic                         busy;

  int                           seed = 32'ha88d29d6;
  int                           cyc = 0;
  int                           rdy_pulses = 0;
  int                           cur_div = `UART_BIT_DIV_DEFAULT;   // Model of the bit period setting
  int                           cur_gap = `UART_GAP_BITS_DEFAULT;
  int                           cur_timeout = `UART_TIMEOUT_BITS_DEFAULT;
  uart_frame_pkg::parity_mode_t cur_par = `UART_PARITY_DEFAULT;

  uart_bridge uart_bridge_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .read_data   (read_data),
    .read_rdy    (read_rdy),
    .read_status (read_status),
    .tx          (tx),
    .rx          (rx),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .busy        (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  always @(negedge clk)
    if (read_rdy === 1'b1)
      rdy_pulses <= rdy_pulses + 1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Error reporting and compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR: %s", what);
    stop_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_status(input string name, input uart_cmd_pkg::rsp_status_t got,
                              input uart_cmd_pkg::rsp_status_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // Even parity makes the total count of ones even, odd makes it odd
  function automatic logic parity_bit(input logic [7:0] b, input uart_frame_pkg::parity_mode_t m);
    parity_bit = (m == uart_frame_pkg::PARITY_ODD) ? ~(^b) : ^b;
  endfunction

  function automatic int frame_bits();
    frame_bits = (cur_par == uart_frame_pkg::PARITY_NONE) ? 10 : 11;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus drivers and serial models
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic cfg_write(input uart_cmd_pkg::cfg_addr_t a, input logic [15:0] d);
    @(posedge clk);
    #1;
    cfg_wr    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(posedge clk);
    #1;
    cfg_wr = 1'b0;
  endtask

  task automatic readback_cfg(input uart_cmd_pkg::cfg_addr_t a, input logic [15:0] exp);
    @(posedge clk);
    #1;
    cfg_addr = a;
    @(negedge clk);
    check_word("cfg_rdata", cfg_rdata, exp);
  endtask

  task automatic wait_idle();
    int guard;
    guard = 0;
    @(negedge clk);
    while (cmd_rdy !== 1'b1)
    begin
      guard++;
      if (guard > 100 * (cur_div + 1) + 200)
        report_error("timeout waiting for cmd_rdy to rise");
      @(negedge clk);
    end
  endtask

  task automatic send_cmd(input logic [15:0] w);
    @(posedge clk);
    #1;
    cmd_in  = w;
    cmd_vld = 1'b1;
    wait_idle();   // Accepted on the next rising edge
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  // Every sample of a bit period must match, which also pins the bit length
  task automatic capture_frame(output logic [7:0] data, output int start_cyc);
    int          guard;
    int          k;
    int          c;
    logic [10:0] bits;
    guard = 0;
    @(negedge clk);
    while (tx !== 1'b0)
    begin
      guard++;
      if (guard > 64 * (cur_div + 1) + 200)
        report_error("timeout waiting for a start bit on tx");
      @(negedge clk);
    end
    start_cyc = cyc;
    for (k = 0; k < frame_bits(); k++)
      for (c = 0; c <= cur_div; c++)
      begin
        if (k != 0 || c != 0)
          @(negedge clk);
        if (c == 0)
          bits[k] = tx;
        else if (tx !== bits[k])
          report_error("tx changed inside a bit period");
      end
    data = bits[8:1];
    if (cur_par != uart_frame_pkg::PARITY_NONE)
      check_bit("tx parity bit", bits[9], parity_bit(data, cur_par));
    check_bit("tx stop bit", bits[frame_bits() - 1], 1'b1);
  endtask

  task automatic capture_command(input logic [15:0] w);
    logic [7:0] b_hi;
    logic [7:0] b_lo;
    int         t_hi;
    int         t_lo;
    capture_frame(b_hi, t_hi);
    capture_frame(b_lo, t_lo);
    check_byte("tx high byte", b_hi, w[15:8]);
    check_byte("tx low byte", b_lo, w[7:0]);
    if (t_lo - t_hi < (frame_bits() + cur_gap) * (cur_div + 1))
      report_error("idle gap between the command frames is too short");
  endtask

  task automatic drive_rsp(input logic [7:0] b, input bit bad_par, input bit bad_stop);
    logic [10:0] bits;
    int          k;
    bits      = '1;
    bits[0]   = 1'b0;
    bits[8:1] = b;
    if (cur_par != uart_frame_pkg::PARITY_NONE)
      bits[9] = parity_bit(b, cur_par) ^ bad_par;
    bits[frame_bits() - 1] = !bad_stop;
    @(posedge clk);
    #1;
    for (k = 0; k < frame_bits(); k++)
    begin
      rx = bits[k];
      repeat (cur_div + 1) @(posedge clk);
      #1;
    end
    rx = 1'b1;
  endtask

  task automatic wait_read(output logic [7:0] d, output uart_cmd_pkg::rsp_status_t s,
                           output int at_cyc);
    int guard;
    guard = 0;
    @(negedge clk);
    while (read_rdy !== 1'b1)
    begin
      guard++;
      if (guard > (cur_timeout + 30) * (cur_div + 1) + 100)
        report_error("timeout waiting for read_rdy");
      @(negedge clk);
    end
    d      = read_data;
    s      = read_status;
    at_cyc = cyc;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic run_write();
    int          r;
    int          pulses;
    logic [15:0] w;
    r      = $random(seed);
    w      = r[15:0];
    w[15]  = 1'b1;
    pulses = rdy_pulses;
    send_cmd(w);
    capture_command(w);
    wait_idle();
    if (rdy_pulses != pulses)
      report_error("read_rdy pulsed during a write command");
  endtask

  task automatic run_read(input logic [7:0] rsp, input bit respond, input bit bad_par,
                          input bit bad_stop, input uart_cmd_pkg::rsp_status_t exp);
    int                        r;
    int                        t_end;
    int                        t_rdy;
    logic [15:0]               w;
    logic [7:0]                d;
    uart_cmd_pkg::rsp_status_t s;
    r     = $random(seed);
    w     = r[15:0];
    w[15] = 1'b0;   // Read
    send_cmd(w);
    capture_command(w);
    t_end = cyc;
    if (respond)
    begin
      repeat (2 * (cur_div + 1)) @(posedge clk);
      fork
        drive_rsp(rsp, bad_par, bad_stop);
        wait_read(d, s, t_rdy);
      join
    end
    else
      wait_read(d, s, t_rdy);
    check_status("read_status", s, exp);
    if (exp == uart_cmd_pkg::RSP_OK)
      check_byte("read_data", d, rsp);
    if (!respond && t_rdy - t_end < cur_timeout * (cur_div + 1))
      report_error("timeout status came before the timeout period");
    wait_idle();
  endtask

  initial
  begin
    int          r;
    logic [15:0] w;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    cfg_wr    = 1'b0;
    cfg_addr  = uart_cmd_pkg::CFG_BIT_DIV;
    cfg_wdata = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    check_bit("tx", tx, 1'b1);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    check_bit("read_rdy", read_rdy, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_byte("read_data", read_data, 8'h00);
    readback_cfg(uart_cmd_pkg::CFG_BIT_DIV, `UART_BIT_DIV_DEFAULT);
    readback_cfg(uart_cmd_pkg::CFG_CTRL,
                 {8'h00, `UART_GAP_BITS_DEFAULT, 2'b00, `UART_PARITY_DEFAULT});
    readback_cfg(uart_cmd_pkg::CFG_TIMEOUT, {8'h00, `UART_TIMEOUT_BITS_DEFAULT});

    run_write();
    r = $random(seed);
    run_read(r[7:0], 1'b1, 1'b0, 1'b0, uart_cmd_pkg::RSP_OK);
    r = $random(seed);
    run_read(r[7:0], 1'b1, 1'b1, 1'b0, uart_cmd_pkg::RSP_PARITY_ERR);
    r = $random(seed);
    run_read(r[7:0], 1'b1, 1'b0, 1'b1, uart_cmd_pkg::RSP_STOP_ERR);
    run_read(8'h00, 1'b0, 1'b0, 1'b0, uart_cmd_pkg::RSP_TIMEOUT);

    // Slower bit period, odd parity and a longer gap
    cfg_write(uart_cmd_pkg::CFG_BIT_DIV, 16'd11);
    cfg_write(uart_cmd_pkg::CFG_CTRL, 16'h0032);
    cur_div = 11;
    cur_gap = 3;
    cur_par = uart_frame_pkg::PARITY_ODD;
    readback_cfg(uart_cmd_pkg::CFG_BIT_DIV, 16'd11);
    readback_cfg(uart_cmd_pkg::CFG_CTRL, 16'h0032);
    run_write();
    r = $random(seed);
    run_read(r[7:0], 1'b1, 1'b0, 1'b0, uart_cmd_pkg::RSP_OK);

    r     = $random(seed);
    w     = r[15:0];
    w[15] = 1'b1;
    send_cmd(w);
    @(negedge clk);
    check_bit("busy", busy, 1'b1);
    cfg_write(uart_cmd_pkg::CFG_BIT_DIV, 16'd3);   // Must be dropped while busy
    wait_idle();
    readback_cfg(uart_cmd_pkg::CFG_BIT_DIV, 16'd11);

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== uart_bridge.f ====
+incdir+.
uart_frame_pkg.sv
uart_cmd_pkg.sv
uart_tx_frame.sv
uart_rx_frame.sv
uart_cmd_ctrl.sv
uart_cfg_regs.sv
uart_bridge.sv
uart_bridge_tb.sv
